// ==== common/fat_pkg.sv ====
/*
 * FAT32 reader shared definitions
 * sector and directory geometry, FAT entry limits,
 * walker state and file-system type enums, target 8.3 name
 */
package fat_pkg;

    localparam int unsigned sector_bytes           = 512;
    localparam int unsigned dir_entry_bytes        = 32;
    localparam int unsigned fat_entries_per_sector = 128;  // 4-byte FAT32 entries

    localparam logic [15:0] boot_signature = 16'h55aa;     // bytes 1FE, 1FF
    localparam logic [31:0] eoc_min        = 32'h0fff_fff8;
    localparam logic [31:0] cluster_mask   = 32'h0fff_ffff; // top nibble reserved

    // space padded short name, first character in the top byte
    localparam logic [87:0] target_name = "EXAMPLE TXT";

    typedef enum logic [2:0] {
        st_reset,
        st_search_mbr,
        st_search_dbr,
        st_ls_root,
        st_fat_lookup_root,
        st_read_file,
        st_fat_lookup_file,
        st_done
    } fat_state_t;

    typedef enum logic [1:0] {
        fs_unassigned,
        fs_unknown,
        fs_fat16,
        fs_fat32
    } fs_type_t;

endpackage

// ==== hw/boot_sector/boot_sector_parser.sv ====
/*
 * Boot-record field capture from the sector byte stream
 * MBR/DBR classification and FAT16/FAT32 detection
 */
`timescale 1ns/100ps

module boot_sector_parser import fat_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        byte_valid,
    input  logic [8:0]  byte_addr,
    input  logic [7:0]  byte_data,
    output logic        is_boot_sector,
    output logic        is_dbr,
    output logic [31:0] part_start,
    output logic        sector_size_ok,
    output logic [7:0]  sec_per_cluster,
    output logic [15:0] resv_sectors,
    output logic [7:0]  num_fats,
    output logic [31:0] fat_size,
    output logic [31:0] root_cluster,
    output fs_type_t    vol_type
);

    logic [15:0] signature;
    logic [7:0]  jump_byte;
    logic [15:0] bytes_per_sec;
    logic [15:0] fat_size16;
    logic [31:0] fat_size32;
    logic [7:0]  type_byte;

    // classification bytes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            signature <= '0;
            jump_byte <= '0;
        end else if (byte_valid) begin
            case (byte_addr)
                9'h000:  jump_byte       <= byte_data;
                9'h1fe:  signature[15:8] <= byte_data;
                9'h1ff:  signature[7:0]  <= byte_data;
                default: ;
            endcase
        end
    end

    // little-endian BPB fields, partition entry 0 start LBA
    always_ff @(posedge clk) begin
        if (byte_valid) begin
            case (byte_addr)
                9'h00b:  bytes_per_sec[7:0]  <= byte_data;
                9'h00c:  bytes_per_sec[15:8] <= byte_data;
                9'h00d:  sec_per_cluster     <= byte_data;
                9'h00e:  resv_sectors[7:0]   <= byte_data;
                9'h00f:  resv_sectors[15:8]  <= byte_data;
                9'h010:  num_fats            <= byte_data;
                9'h016:  fat_size16[7:0]     <= byte_data;
                9'h017:  fat_size16[15:8]    <= byte_data;
                9'h024:  fat_size32[7:0]     <= byte_data;
                9'h025:  fat_size32[15:8]    <= byte_data;
                9'h026:  fat_size32[23:16]   <= byte_data;
                9'h027:  fat_size32[31:24]   <= byte_data;
                9'h02c:  root_cluster[7:0]   <= byte_data;
                9'h02d:  root_cluster[15:8]  <= byte_data;
                9'h02e:  root_cluster[23:16] <= byte_data;
                9'h02f:  root_cluster[31:24] <= byte_data;
                9'h056:  type_byte           <= byte_data; // '2' of "FAT32"
                9'h1c6:  part_start[7:0]     <= byte_data;
                9'h1c7:  part_start[15:8]    <= byte_data;
                9'h1c8:  part_start[23:16]   <= byte_data;
                9'h1c9:  part_start[31:24]   <= byte_data;
                default: ;
            endcase
        end
    end

    assign is_boot_sector = (signature == boot_signature);
    assign is_dbr         = (jump_byte == 8'heb) || (jump_byte == 8'he9);
    assign sector_size_ok = (bytes_per_sec == 16'(sector_bytes));
    assign fat_size       = (fat_size16 != 16'd0) ? {16'd0, fat_size16} : fat_size32;

    always_comb begin
        if (fat_size16 != 16'd0) begin
            vol_type = fs_fat16;
        end else if (type_byte == 8'h32) begin
            vol_type = fs_fat32;
        end else begin
            vol_type = fs_unknown;
        end
    end

endmodule

// ==== hw/dir_scan/dir_entry_matcher.sv ====
/*
 * Directory entry matcher
 * compares each 32-byte entry with the target short name,
 * filters free and directory/volume entries, captures cluster and size
 */
`timescale 1ns/100ps

module dir_entry_matcher import fat_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        dir_active,
    input  logic        byte_valid,
    input  logic [8:0]  byte_addr,
    input  logic [7:0]  byte_data,
    output logic        entry_match,
    output logic [31:0] match_cluster,
    output logic [31:0] match_size
);

    logic [4:0] ofs;
    logic [7:0] name_byte;
    logic       take;
    logic       name_eq;
    logic       in_use;
    logic       attr_ok;

    assign ofs  = byte_addr[4:0];    // offset inside the entry
    assign take = dir_active && byte_valid;

    assign name_byte = (ofs <= 5'd10) ? target_name[8 * (10 - ofs) +: 8] : 8'h00;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            name_eq     <= 1'b0;
            in_use      <= 1'b0;
            attr_ok     <= 1'b0;
            entry_match <= 1'b0;
        end else begin
            entry_match <= 1'b0;
            if (take) begin
                if (ofs == 5'd0) begin
                    name_eq <= (byte_data == name_byte);
                    in_use  <= (byte_data != 8'he5) && (byte_data != 8'h00); // deleted, free
                end else if (ofs <= 5'd10) begin
                    name_eq <= name_eq && (byte_data == name_byte);
                end
                if (ofs == 5'h0b) begin
                    attr_ok <= (byte_data & 8'h18) == 8'h00; // no dir, no volume label
                end
                if (ofs == 5'(dir_entry_bytes - 1)) begin
                    entry_match <= name_eq && in_use && attr_ok;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            case (ofs)
                5'h14:   match_cluster[23:16] <= byte_data; // high half
                5'h15:   match_cluster[31:24] <= byte_data;
                5'h1a:   match_cluster[7:0]   <= byte_data;
                5'h1b:   match_cluster[15:8]  <= byte_data;
                5'h1c:   match_size[7:0]      <= byte_data;
                5'h1d:   match_size[15:8]     <= byte_data;
                5'h1e:   match_size[23:16]    <= byte_data;
                5'h1f:   match_size[31:24]    <= byte_data;
                default: ;
            endcase
        end
    end

endmodule

// ==== hw/fat_walker.sv ====
/*
 * FAT32 walker FSM
 * boot-sector search, volume geometry, root directory and file
 * cluster-chain walks through the FAT, file byte forwarding
 */
`timescale 1ns/100ps

module fat_walker import fat_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        rd_done,
    input  logic        byte_valid,
    input  logic [8:0]  byte_addr,
    input  logic [7:0]  byte_data,
    input  logic        is_boot_sector,
    input  logic        is_dbr,
    input  logic [31:0] part_start,
    input  logic        sector_size_ok,
    input  logic [7:0]  sec_per_cluster,
    input  logic [15:0] resv_sectors,
    input  logic [7:0]  num_fats,
    input  logic [31:0] fat_size,
    input  logic [31:0] root_cluster,
    input  fs_type_t    vol_type,
    input  logic        entry_match,
    input  logic [31:0] match_cluster,
    input  logic [31:0] match_size,
    output logic        rd_start,
    output logic [31:0] rd_sector,
    output logic        dir_active,
    output fs_type_t    fs_type,
    output fat_state_t  fat_state,
    output logic        file_found,
    output logic        file_byte_valid,
    output logic [7:0]  file_byte
);

    logic        busy;               // read in flight
    logic [31:0] cur_cluster;
    logic [7:0]  sec_off;            // sector inside the cluster
    logic [7:0]  spc;
    logic [31:0] fat_start;
    logic [31:0] data_base;          // sector of cluster 0
    logic [31:0] fat_entry;
    logic [31:0] file_cluster;
    logic [31:0] file_size;
    logic [31:0] byte_cnt;

    logic [31:0] geo_fat_start;
    logic [31:0] geo_data_base;
    logic [31:0] root_lba;
    logic [6:0]  fat_index;
    logic [31:0] next_cluster;
    logic        chain_end;
    logic        last_in_cluster;
    logic        fat_lookup;
    logic        found_now;
    logic [31:0] start_cluster;

    function automatic logic [31:0] cluster_lba(input logic [31:0] c);
        return data_base + c * {24'd0, spc};
    endfunction

    // geometry from the DBR currently held by the parser
    assign geo_fat_start = rd_sector + {16'd0, resv_sectors};
    assign geo_data_base = geo_fat_start + {24'd0, num_fats} * fat_size
                         - {23'd0, sec_per_cluster, 1'b0};
    assign root_lba      = geo_data_base + root_cluster * {24'd0, sec_per_cluster};

    assign fat_index       = 7'(cur_cluster % fat_entries_per_sector);
    assign next_cluster    = fat_entry & cluster_mask;
    assign chain_end       = (next_cluster >= eoc_min) || (next_cluster < 32'd2);
    assign last_in_cluster = ({1'b0, sec_off} + 9'd1) >= {1'b0, spc};
    assign fat_lookup      = (fat_state == st_fat_lookup_root) ||
                             (fat_state == st_fat_lookup_file);

    // a match can land on the same cycle as the sector's rd_done
    assign found_now     = file_found || entry_match;
    assign start_cluster = file_found ? file_cluster : match_cluster;

    assign dir_active = (fat_state == st_ls_root);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fat_state   <= st_reset;
            fs_type     <= fs_unassigned;
            rd_start    <= 1'b0;
            busy        <= 1'b0;
            rd_sector   <= '0;
            cur_cluster <= '0;
            sec_off     <= '0;
            spc         <= '0;
            fat_start   <= '0;
            data_base   <= '0;
        end else begin
            rd_start <= 1'b0;
            if (rd_done) begin
                busy <= 1'b0;
                case (fat_state)
                    st_search_mbr: begin
                        if (is_boot_sector) begin
                            fat_state <= st_search_dbr;
                            if (!is_dbr) begin
                                rd_sector <= part_start; // follow partition 0
                            end
                        end else begin
                            rd_sector <= rd_sector + 32'd1;
                        end
                    end
                    st_search_dbr: begin
                        if (!(is_boot_sector && is_dbr)) begin
                            fs_type   <= fs_unknown;
                            fat_state <= st_done;
                        end else begin
                            fs_type <= vol_type;
                            if (!sector_size_ok || vol_type != fs_fat32) begin
                                fat_state <= st_done;
                            end else begin
                                spc         <= sec_per_cluster;
                                fat_start   <= geo_fat_start;
                                data_base   <= geo_data_base;
                                cur_cluster <= root_cluster;
                                sec_off     <= '0;
                                rd_sector   <= root_lba;
                                fat_state   <= st_ls_root;
                            end
                        end
                    end
                    st_ls_root, st_read_file: begin
                        if (fat_state == st_ls_root && found_now) begin
                            cur_cluster <= start_cluster;
                            sec_off     <= '0;
                            rd_sector   <= cluster_lba(start_cluster);
                            fat_state   <= st_read_file;
                        end else if (!last_in_cluster) begin
                            sec_off   <= sec_off + 8'd1;
                            rd_sector <= rd_sector + 32'd1;
                        end else begin
                            rd_sector <= fat_start + cur_cluster / fat_entries_per_sector;
                            fat_state <= (fat_state == st_ls_root) ? st_fat_lookup_root
                                                                   : st_fat_lookup_file;
                        end
                    end
                    st_fat_lookup_root, st_fat_lookup_file: begin
                        if (chain_end) begin
                            fat_state <= st_done;
                        end else begin
                            cur_cluster <= next_cluster;
                            sec_off     <= '0;
                            rd_sector   <= cluster_lba(next_cluster);
                            fat_state   <= (fat_state == st_fat_lookup_root) ? st_ls_root
                                                                             : st_read_file;
                        end
                    end
                    default: ;
                endcase
            end else if (fat_state == st_reset) begin
                fat_state <= st_search_mbr;
            end else if (fat_state != st_done && !busy) begin
                rd_start <= 1'b1;
                busy     <= 1'b1;
            end
        end
    end

    // file flag and size-limited byte forwarding
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            file_found      <= 1'b0;
            byte_cnt        <= '0;
            file_byte_valid <= 1'b0;
        end else begin
            if (entry_match) begin
                file_found <= 1'b1;
            end
            file_byte_valid <= 1'b0;
            if (byte_valid && fat_state == st_read_file && byte_cnt < file_size) begin
                file_byte_valid <= 1'b1;
                byte_cnt        <= byte_cnt + 32'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        file_byte <= byte_data;
        if (entry_match && !file_found) begin
            file_cluster <= match_cluster;   // first match wins
            file_size    <= match_size;
        end
        if (byte_valid && fat_lookup && byte_addr[8:2] == fat_index) begin
            fat_entry[8 * byte_addr[1:0] +: 8] <= byte_data;
        end
    end

endmodule

// ==== hw/fat_reader_top.sv ====
/*
 * FAT32 file reader top level
 * boot-sector parser and directory matcher on the sector byte stream,
 * FAT walker driving the sector port and the file byte output
 */
`timescale 1ns/100ps

module fat_reader_top import fat_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    output logic        rd_start,
    output logic [31:0] rd_sector,
    input  logic        rd_done,
    input  logic        byte_valid,
    input  logic [8:0]  byte_addr,
    input  logic [7:0]  byte_data,
    output fs_type_t    fs_type,
    output fat_state_t  fat_state,
    output logic        file_found,
    output logic        file_byte_valid,
    output logic [7:0]  file_byte
);

    logic        is_boot_sector;
    logic        is_dbr;
    logic [31:0] part_start;
    logic        sector_size_ok;
    logic [7:0]  sec_per_cluster;
    logic [15:0] resv_sectors;
    logic [7:0]  num_fats;
    logic [31:0] fat_size;
    logic [31:0] root_cluster;
    fs_type_t    vol_type;

    logic        dir_active;
    logic        entry_match;
    logic [31:0] match_cluster;
    logic [31:0] match_size;

    boot_sector_parser i_parser (
        .clk             (clk),
        .rst_n           (rst_n),
        .byte_valid      (byte_valid),
        .byte_addr       (byte_addr),
        .byte_data       (byte_data),
        .is_boot_sector  (is_boot_sector),
        .is_dbr          (is_dbr),
        .part_start      (part_start),
        .sector_size_ok  (sector_size_ok),
        .sec_per_cluster (sec_per_cluster),
        .resv_sectors    (resv_sectors),
        .num_fats        (num_fats),
        .fat_size        (fat_size),
        .root_cluster    (root_cluster),
        .vol_type        (vol_type)
    );

    dir_entry_matcher i_matcher (
        .clk           (clk),
        .rst_n         (rst_n),
        .dir_active    (dir_active),
        .byte_valid    (byte_valid),
        .byte_addr     (byte_addr),
        .byte_data     (byte_data),
        .entry_match   (entry_match),
        .match_cluster (match_cluster),
        .match_size    (match_size)
    );

    fat_walker i_walker (
        .clk             (clk),
        .rst_n           (rst_n),
        .rd_done         (rd_done),
        .byte_valid      (byte_valid),
        .byte_addr       (byte_addr),
        .byte_data       (byte_data),
        .is_boot_sector  (is_boot_sector),
        .is_dbr          (is_dbr),
        .part_start      (part_start),
        .sector_size_ok  (sector_size_ok),
        .sec_per_cluster (sec_per_cluster),
        .resv_sectors    (resv_sectors),
        .num_fats        (num_fats),
        .fat_size        (fat_size),
        .root_cluster    (root_cluster),
        .vol_type        (vol_type),
        .entry_match     (entry_match),
        .match_cluster   (match_cluster),
        .match_size      (match_size),
        .rd_start        (rd_start),
        .rd_sector       (rd_sector),
        .dir_active      (dir_active),
        .fs_type         (fs_type),
        .fat_state       (fat_state),
        .file_found      (file_found),
        .file_byte_valid (file_byte_valid),
        .file_byte       (file_byte)
    );

endmodule

// ==== bench/tb_clock_gen.sv ====
/*
 * Testbench clock and reset
 * 40 ns clock, active-low reset held for 10 cycles at start
 * and again on each reset request
 */
`timescale 1ns/100ps

module tb_clock_gen (
    input  logic reset_req,
    output logic clk,
    output logic rst_n
);

    localparam int half_period  = 20;
    localparam int reset_cycles = 10;

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    always begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;            // release on the falling edge
        @(posedge reset_req);
    end

endmodule

// ==== bench/disk_model.sv ====
/*
 * Sector-read responder
 * byte image filled by the testbench, 512 ascending beats per read
 * with irregular gaps, one rd_done strobe after the last byte
 */
`timescale 1ns/100ps

module disk_model import fat_pkg::*; #(
    parameter int sectors = 128
) (
    input  logic        clk,
    input  logic        rd_start,
    input  logic [31:0] rd_sector,
    output logic        rd_done,
    output logic        byte_valid,
    output logic [8:0]  byte_addr,
    output logic [7:0]  byte_data
);

    logic [7:0] img [0:sectors * sector_bytes - 1];

    // idle cycle after some beats
    function automatic bit gap_after(input int i);
        return (i % 7 == 3) || (i % 13 == 0);
    endfunction

    task automatic serve(input logic [31:0] sector);
        for (int i = 0; i < sector_bytes; i++) begin
            @(negedge clk);
            byte_valid = 1'b1;
            byte_addr  = 9'(i);
            if (sector < sectors) begin
                byte_data = img[sector * sector_bytes + i];
            end else begin
                byte_data = 8'h00;    // beyond the image
            end
            if (gap_after(i)) begin
                @(negedge clk);
                byte_valid = 1'b0;
            end
        end
        @(negedge clk);
        byte_valid = 1'b0;
        rd_done    = 1'b1;
        @(negedge clk);
        rd_done = 1'b0;
    endtask

    initial begin
        rd_done    = 1'b0;
        byte_valid = 1'b0;
        byte_addr  = '0;
        byte_data  = '0;
        forever begin
            @(negedge clk);              // strobe is stable here
            if (rd_start) begin
                serve(rd_sector);
            end
        end
    end

endmodule

// ==== bench/fat_reader_tb.sv ====
/*
 * FAT32 reader testbench
 * disk image builder, runs over MBR and bare DBR volumes, chained root,
 * missing name and FAT16, byte stream and sector-port checks
 */
`timescale 1ns/100ps

module fat_reader_tb import fat_pkg::*; ();

    localparam int disk_sectors = 128;
    localparam int resv         = 32;
    localparam int fats         = 2;
    localparam int fat_len      = 4;       // sectors per FAT
    localparam int spc          = 2;       // sectors per cluster
    localparam int file_size    = 1500;
    localparam int wait_limit   = 20000;

    logic        clk;
    logic        rst_n;
    logic        reset_req;
    logic        rd_start;
    logic [31:0] rd_sector;
    logic        rd_done;
    logic        byte_valid;
    logic [8:0]  byte_addr;
    logic [7:0]  byte_data;
    fs_type_t    fs_type;
    fat_state_t  fat_state;
    logic        file_found;
    logic        file_byte_valid;
    logic [7:0]  file_byte;

    logic [31:0] lfsr;
    int          errors;
    int          rcv_count;
    string       test_name;
    logic        read_open;
    logic [7:0]  file_data [0:4 * sector_bytes - 1];

    tb_clock_gen i_clock (
        .reset_req (reset_req),
        .clk       (clk),
        .rst_n     (rst_n)
    );

    disk_model #(.sectors(disk_sectors)) i_disk (
        .clk        (clk),
        .rd_start   (rd_start),
        .rd_sector  (rd_sector),
        .rd_done    (rd_done),
        .byte_valid (byte_valid),
        .byte_addr  (byte_addr),
        .byte_data  (byte_data)
    );

    fat_reader_top i_dut (
        .clk             (clk),
        .rst_n           (rst_n),
        .rd_start        (rd_start),
        .rd_sector       (rd_sector),
        .rd_done         (rd_done),
        .byte_valid      (byte_valid),
        .byte_addr       (byte_addr),
        .byte_data       (byte_data),
        .fs_type         (fs_type),
        .fat_state       (fat_state),
        .file_found      (file_found),
        .file_byte_valid (file_byte_valid),
        .file_byte       (file_byte)
    );

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [7:0] random_byte();
        logic [7:0] b;
        b = '0;
        for (int k = 0; k < 8; k++) begin
            lfsr = lfsr_step(lfsr);
            b    = {b[6:0], lfsr[0]};
        end
        return b;
    endfunction

    function automatic int cluster_lba(input int dbr_lba, input int c);
        return dbr_lba + resv + fats * fat_len - 2 * spc + c * spc;
    endfunction

    task automatic put_le(input int a, input logic [31:0] v, input int n);
        for (int k = 0; k < n; k++) begin
            i_disk.img[a + k] = v[8 * k +: 8];
        end
    endtask

    task automatic put_entry(input int lba, input int slot, input logic [87:0] name,
                             input logic [7:0] attr, input logic [31:0] cluster,
                             input logic [31:0] size);
        int a;
        a = lba * sector_bytes + slot * dir_entry_bytes;
        for (int k = 0; k < 11; k++) begin
            i_disk.img[a + k] = name[87 - 8 * k -: 8];    // first character first
        end
        i_disk.img[a + 11] = attr;
        put_le(a + 20, cluster[31:16], 2);
        put_le(a + 26, cluster[15:0], 2);
        put_le(a + 28, size, 4);
    endtask

    task automatic build_image(input int dbr_lba, input int root_slot, input bit fat16);
        int dbr;
        int fat;
        int root;
        logic [7:0] b;
        for (int a = 0; a < disk_sectors * sector_bytes; a++) begin
            i_disk.img[a] = 8'(a ^ (a >> 8));
        end
        if (dbr_lba != 0) begin
            i_disk.img[0] = 8'hfa;                   // boot code, no jump
            put_le(16'h1c6, dbr_lba, 4);
            i_disk.img[510] = 8'h55;
            i_disk.img[511] = 8'haa;
        end
        dbr = dbr_lba * sector_bytes;
        i_disk.img[dbr] = 8'heb;
        put_le(dbr + 11, sector_bytes, 2);
        i_disk.img[dbr + 13] = 8'(spc);
        put_le(dbr + 14, resv, 2);
        i_disk.img[dbr + 16] = 8'(fats);
        put_le(dbr + 22, fat16 ? fat_len : 0, 2);
        put_le(dbr + 36, fat_len, 4);
        put_le(dbr + 44, 2, 4);                      // root starts at cluster 2
        i_disk.img[dbr + 86]  = fat16 ? 8'h36 : 8'h32;
        i_disk.img[dbr + 510] = 8'h55;
        i_disk.img[dbr + 511] = 8'haa;
        fat = (dbr_lba + resv) * sector_bytes;
        put_le(fat + 4 * 2, 3, 4);
        put_le(fat + 4 * 3, 32'h0fff_ffff, 4);
        put_le(fat + 4 * 5, 32'h1000_0009, 4);       // reserved nibble set
        put_le(fat + 4 * 9, 32'hf0ff_fff8, 4);
        root = cluster_lba(dbr_lba, 2);
        put_entry(root, 0, {8'he5, "XAMPLE TXT"}, 8'h20, 7, file_size);
        put_entry(root, 1, "EXAMPLE TXT", 8'h10, 7, 0);   // subdirectory
        put_entry(root, 2, "EXAMPLE TXT", 8'h08, 0, 0);   // volume label
        put_entry(root, 3, "OTHER   TXT", 8'h20, 7, 64);
        if (root_slot == 2) begin
            put_entry(root + 1, 5, "EXAMPLE TXT", 8'h21, 5, file_size);
        end else if (root_slot == 3) begin
            put_entry(cluster_lba(dbr_lba, 3) + 1, 15, "EXAMPLE TXT", 8'h21, 5, file_size);
        end
        for (int a = 0; a < 2 * spc * sector_bytes; a++) begin
            b = random_byte();
            file_data[a] = b;
            if (a < spc * sector_bytes) begin
                i_disk.img[cluster_lba(dbr_lba, 5) * sector_bytes + a] = b;
            end else begin
                i_disk.img[cluster_lba(dbr_lba, 9) * sector_bytes + a - spc * sector_bytes] = b;
            end
        end
    endtask

    task automatic compare(input string what, input int expected, input int actual);
        assert (expected == actual) else begin
            errors++;
            $display("MISMATCH %s %s expected %0d actual %0d", test_name, what, expected, actual);
        end
    endtask

    task automatic reset_dut();
        int n;
        @(negedge clk);
        reset_req = 1'b1;
        @(negedge clk);
        reset_req = 1'b0;
        compare("rd_start in reset", 0, rd_start);
        compare("file_byte_valid in reset", 0, file_byte_valid);
        compare("file_found in reset", 0, file_found);
        compare("fat_state in reset", st_reset, fat_state);
        compare("fs_type in reset", fs_unassigned, fs_type);
        n = 0;
        while (!rst_n && n < 40) begin
            @(negedge clk);
            n++;
        end
        if (!rst_n) begin
            $display("%s: reset was never released", test_name);
            $display("test failed");
            $finish;
        end
    endtask

    task automatic wait_done();
        int n;
        n = 0;
        while (fat_state != st_done && n < wait_limit) begin
            @(negedge clk);
            n++;
        end
        if (fat_state != st_done) begin
            $display("%s: reader stuck in state %0d after %0d cycles", test_name, fat_state, n);
            $display("test failed");
            $finish;
        end
    endtask

    task automatic run_case(input string name, input int dbr_lba, input int root_slot,
                            input bit fat16);
        bit has_file;
        has_file  = (root_slot != 0) && !fat16;
        test_name = name;
        build_image(dbr_lba, root_slot, fat16);
        rcv_count = 0;
        reset_dut();
        wait_done();
        compare("fs_type", fat16 ? fs_fat16 : fs_fat32, fs_type);
        compare("file_found", has_file, file_found);
        compare("file byte count", has_file ? file_size : 0, rcv_count);
    endtask

    // file bytes in file-offset order
    always @(negedge clk) begin
        if (rst_n && file_byte_valid) begin
            if (rcv_count < file_size) begin
                assert (file_byte == file_data[rcv_count]) else begin
                    errors++;
                    $display("MISMATCH %s byte %0d expected %02h actual %02h", test_name,
                             rcv_count, file_data[rcv_count], file_byte);
                end
            end
            rcv_count++;
        end
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            read_open <= 1'b0;
        end else if (rd_start) begin
            read_open <= 1'b1;
        end else if (rd_done) begin
            read_open <= 1'b0;
        end
    end

    // one sector read at a time
    assert property (@(posedge clk) disable iff (!rst_n) rd_start |-> !read_open)
        else begin
            errors++;
            $display("%s: read of sector %0d started before the previous read finished",
                     test_name, rd_sector);
        end

    initial begin
        reset_req = 1'b0;
        errors    = 0;
        rcv_count = 0;
        lfsr      = 32'hd325;
        test_name = "power_on";
        run_case("base", 64, 2, 1'b0);
        run_case("root_chain", 64, 3, 1'b0);
        run_case("no_mbr", 0, 3, 1'b0);
        run_case("name_absent", 64, 0, 1'b0);
        run_case("fat16", 64, 2, 1'b1);
        $display("5 runs, %0d errors", errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== src.f ====
common/fat_pkg.sv
hw/boot_sector/boot_sector_parser.sv
hw/dir_scan/dir_entry_matcher.sv
hw/fat_walker.sv
hw/fat_reader_top.sv
bench/tb_clock_gen.sv
bench/disk_model.sv
bench/fat_reader_tb.sv
